// File: vlog.f
+incdir+include
source/mips_isa_pkg.sv
source/core_pipe_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mips_core.sv
bench/core_tb.sv

// File: include/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// SPECIAL form with two register sources
function automatic mips_isa_pkg::inst_t rtype_inst(
    input mips_isa_pkg::funct_t    fn,
    input mips_isa_pkg::reg_addr_t rd,
    input mips_isa_pkg::reg_addr_t rs,
    input mips_isa_pkg::reg_addr_t rt
);
    return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

// shift by the amount held in the instruction
function automatic mips_isa_pkg::inst_t shift_inst(
    input mips_isa_pkg::funct_t    fn,
    input mips_isa_pkg::reg_addr_t rd,
    input mips_isa_pkg::reg_addr_t rt,
    input mips_isa_pkg::shamt_t    sa
);
    return {mips_isa_pkg::OP_SPECIAL, 5'd0, rt, rd, sa, fn};
endfunction

// immediate in the low half
function automatic mips_isa_pkg::inst_t itype_inst(
    input mips_isa_pkg::opcode_t   op,
    input mips_isa_pkg::reg_addr_t rt,
    input mips_isa_pkg::reg_addr_t rs,
    input logic [15:0]             imm
);
    return {op, rs, rt, imm};
endfunction

`endif

// File: bench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    // expected outcome of one issue slot
    typedef struct packed {
        logic                    slot;
        logic                    valid;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } exp_t;

    localparam int RESET_CYCLES   = 10;
    localparam int QUIET_CYCLES   = 8;
    localparam int NUM_ISSUES     = 117;
    // six tests, each drains within four cycles
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + QUIET_CYCLES + NUM_ISSUES + 4 * 6 + 20;

    logic                    clk;
    logic                    arst_n_i;
    logic                    inst_valid_i;
    mips_isa_pkg::inst_t     inst_i;
    logic                    wb_valid_o;
    mips_isa_pkg::reg_addr_t wb_addr_o;
    mips_isa_pkg::word_t     wb_data_o;

    exp_t                exp_in;
    exp_t                exp_s1;
    exp_t                exp_s2;
    mips_isa_pkg::word_t shadow [32];
    integer              seed;
    int                  issued_cnt;
    int                  checked_cnt;
    int                  fail_cnt;
    int                  test_base;
    int                  cycles;

    `include "tb_encode.svh"

    mips_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // two stages, same fixed latency as the core
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_s1      <= '0;
            exp_s2      <= '0;
            checked_cnt <= 0;
        end else begin
            exp_s1 <= exp_in;
            exp_s2 <= exp_s1;
            if (exp_s2.slot) begin
                checked_cnt <= checked_cnt + 1;
            end
        end
    end

    commit_check_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (wb_valid_o == exp_s2.valid)
            && (!exp_s2.valid || ((wb_addr_o == exp_s2.addr) && (wb_data_o == exp_s2.data)))
    ) else begin
        fail_cnt++;
        $display("[FAIL] %0t: commit %b r%0d=%h, expected %b r%0d=%h", $time,
                 $sampled(wb_valid_o), $sampled(wb_addr_o), $sampled(wb_data_o),
                 $sampled(exp_s2.valid), $sampled(exp_s2.addr), $sampled(exp_s2.data));
    end

    quiet_reset_a: assert property (
        @(posedge clk) !arst_n_i |-> !wb_valid_o
    ) else begin
        fail_cnt++;
        $display("[FAIL] %0t: commit strobe high during reset", $time);
    end

    // architectural result against the shadow registers
    function automatic exp_t predict(input mips_isa_pkg::inst_t in);
        exp_t                e;
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t zimm;
        mips_isa_pkg::word_t simm;
        logic                known;
        a      = shadow[in.rs];
        b      = shadow[in.rt];
        zimm   = {16'h0000, in[15:0]};
        simm   = {{16{in[15]}}, in[15:0]};
        known  = 1'b1;
        e      = '0;
        e.addr = in.rt;
        case (in.op)
            mips_isa_pkg::OP_SPECIAL: begin
                e.addr = in.rd;
                case (in.funct)
                    mips_isa_pkg::FN_OR:   e.data = a | b;
                    mips_isa_pkg::FN_AND:  e.data = a & b;
                    mips_isa_pkg::FN_XOR:  e.data = a ^ b;
                    mips_isa_pkg::FN_NOR:  e.data = ~(a | b);
                    mips_isa_pkg::FN_SLL:  e.data = b << in.shamt;
                    mips_isa_pkg::FN_SRL:  e.data = b >> in.shamt;
                    mips_isa_pkg::FN_SRA:  e.data = $signed(b) >>> in.shamt;
                    mips_isa_pkg::FN_SLLV: e.data = b << a[4:0];
                    mips_isa_pkg::FN_SRLV: e.data = b >> a[4:0];
                    mips_isa_pkg::FN_SRAV: e.data = $signed(b) >>> a[4:0];
                    mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU: e.data = a + b;
                    mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU: e.data = a - b;
                    mips_isa_pkg::FN_SLT:  e.data = {31'd0, $signed(a) < $signed(b)};
                    mips_isa_pkg::FN_SLTU: e.data = {31'd0, a < b};
                    default:               known = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ORI:   e.data = a | zimm;
            mips_isa_pkg::OP_ANDI:  e.data = a & zimm;
            mips_isa_pkg::OP_XORI:  e.data = a ^ zimm;
            mips_isa_pkg::OP_LUI:   e.data = {in[15:0], 16'h0000};
            mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU: e.data = a + simm;
            mips_isa_pkg::OP_SLTI:  e.data = {31'd0, $signed(a) < $signed(simm)};
            mips_isa_pkg::OP_SLTIU: e.data = {31'd0, a < simm};
            default:                known = 1'b0;
        endcase
        e.slot  = 1'b1;
        e.valid = known && (e.addr != 5'd0);
        return e;
    endfunction

    task automatic issue(input mips_isa_pkg::inst_t in);
        exp_t e;
        e = predict(in);
        if (e.valid) begin
            shadow[e.addr] = e.data;
        end
        inst_valid_i <= 1'b1;
        inst_i       <= in;
        exp_in       <= e;
        issued_cnt++;
        @(posedge clk);
    endtask

    task automatic load_reg(input mips_isa_pkg::reg_addr_t r, input mips_isa_pkg::word_t v);
        issue(itype_inst(mips_isa_pkg::OP_LUI, r, 5'd0, v[31:16]));
        issue(itype_inst(mips_isa_pkg::OP_ORI, r, r, v[15:0]));
    endtask

    task automatic close_test(input string name);
        inst_valid_i <= 1'b0;
        exp_in       <= '0;
        while (checked_cnt != issued_cnt) begin
            @(posedge clk);
        end
        $display("%s: %0d failed checks", name, fail_cnt - test_base);
        test_base = fail_cnt;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed         = 32'h4294_cafe;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        exp_in       = '0;
        issued_cnt   = 0;
        fail_cnt     = 0;
        test_base    = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (QUIET_CYCLES) @(posedge clk);
        close_test("quiet reset");

        issue(itype_inst(mips_isa_pkg::OP_ORI, 5'd1, 5'd0, 16'h8a5c));
        issue(itype_inst(mips_isa_pkg::OP_LUI, 5'd2, 5'd0, 16'hdead));
        issue(itype_inst(mips_isa_pkg::OP_ORI, 5'd2, 5'd2, 16'hbeef));
        issue(itype_inst(mips_isa_pkg::OP_ANDI, 5'd3, 5'd2, 16'hf0f0));
        issue(itype_inst(mips_isa_pkg::OP_XORI, 5'd4, 5'd2, 16'hffff));
        close_test("logic immediates");

        // r6 negative, r7 positive
        repeat (4) begin
            load_reg(5'd5, 32'($random(seed)));
            load_reg(5'd6, 32'($random(seed)) | 32'h8000_0000);
            load_reg(5'd7, 32'($random(seed)) & 32'h7fff_ffff);
            issue(rtype_inst(mips_isa_pkg::FN_NOR, 5'd8, 5'd5, 5'd6));
            issue(rtype_inst(mips_isa_pkg::FN_ADDU, 5'd9, 5'd5, 5'd6));
            issue(rtype_inst(mips_isa_pkg::FN_SUB, 5'd10, 5'd7, 5'd6));
            issue(rtype_inst(mips_isa_pkg::FN_SLT, 5'd11, 5'd6, 5'd7));
            issue(rtype_inst(mips_isa_pkg::FN_SLTU, 5'd12, 5'd6, 5'd7));
            issue(itype_inst(mips_isa_pkg::OP_ADDI, 5'd13, 5'd6, 16'h8001));
            issue(itype_inst(mips_isa_pkg::OP_SLTI, 5'd14, 5'd6, 16'hfff0));
            issue(itype_inst(mips_isa_pkg::OP_SLTIU, 5'd15, 5'd7, 16'hfff0));
        end
        close_test("register alu");

        repeat (3) begin
            load_reg(5'd16, 32'($random(seed)) | 32'h8000_0000);
            load_reg(5'd17, 32'($random(seed)));
            issue(shift_inst(mips_isa_pkg::FN_SLL, 5'd18, 5'd16, 5'($random(seed))));
            issue(shift_inst(mips_isa_pkg::FN_SRL, 5'd19, 5'd16, 5'($random(seed))));
            issue(shift_inst(mips_isa_pkg::FN_SRA, 5'd20, 5'd16, 5'($random(seed))));
            issue(rtype_inst(mips_isa_pkg::FN_SLLV, 5'd21, 5'd17, 5'd16));
            issue(rtype_inst(mips_isa_pkg::FN_SRLV, 5'd22, 5'd17, 5'd16));
            issue(rtype_inst(mips_isa_pkg::FN_SRAV, 5'd23, 5'd17, 5'd16));
        end
        close_test("shifts");

        // r24 read at distance 1, 2 and 3; r28 has two writes in flight
        repeat (3) begin
            issue(itype_inst(mips_isa_pkg::OP_ADDIU, 5'd24, 5'd0, 16'($random(seed))));
            issue(rtype_inst(mips_isa_pkg::FN_ADDU, 5'd25, 5'd24, 5'd24));
            issue(rtype_inst(mips_isa_pkg::FN_SUBU, 5'd26, 5'd0, 5'd24));
            issue(rtype_inst(mips_isa_pkg::FN_XOR, 5'd27, 5'd24, 5'd25));
            issue(itype_inst(mips_isa_pkg::OP_ADDIU, 5'd28, 5'd0, 16'($random(seed))));
            issue(itype_inst(mips_isa_pkg::OP_ADDIU, 5'd28, 5'd0, 16'($random(seed))));
            issue(rtype_inst(mips_isa_pkg::FN_ADDU, 5'd29, 5'd28, 5'd28));
        end
        close_test("forwarding");

        issue(itype_inst(6'b111111, 5'd30, 5'd0, 16'h1234));
        issue(rtype_inst(6'b001000, 5'd30, 5'd1, 5'd2));
        issue(itype_inst(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        issue(rtype_inst(mips_isa_pkg::FN_OR, 5'd31, 5'd0, 5'd0));
        issue(rtype_inst(mips_isa_pkg::FN_ADDU, 5'd30, 5'd0, 5'd1));
        close_test("no commit");

        $display("%0d issued, %0d checked, %0d failed checks",
                 issued_cnt, checked_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: source/mips_core.sv
`timescale 1ns/100ps

module mips_core (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    inst_valid_i,
    input  mips_isa_pkg::inst_t     inst_i,
    output logic                    wb_valid_o,
    output mips_isa_pkg::reg_addr_t wb_addr_o,
    output mips_isa_pkg::word_t     wb_data_o
);

    mips_isa_pkg::reg_addr_t rs_addr;
    mips_isa_pkg::reg_addr_t rt_addr;
    mips_isa_pkg::word_t     rs_data;
    mips_isa_pkg::word_t     rt_data;
    core_pipe_pkg::id_ex_t   id_ex;
    core_pipe_pkg::wb_t      ex_fwd;
    core_pipe_pkg::wb_t      wb_fwd;

    decode_stage decode_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs_addr_o    (rs_addr),
        .rt_addr_o    (rt_addr),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_fwd),
        .id_ex_o      (id_ex)
    );

    execute_stage execute_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_fwd_o (wb_fwd)
    );

    // writeback result is also the register write
    reg_file reg_file_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wr_i      (wb_fwd)
    );

    // commit port
    assign wb_valid_o = wb_fwd.valid;
    assign wb_addr_o  = wb_fwd.dest;
    assign wb_data_o  = wb_fwd.data;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  core_pipe_pkg::id_ex_t id_ex_i,
    output core_pipe_pkg::wb_t    ex_fwd_o,
    output core_pipe_pkg::wb_t    wb_fwd_o
);

    logic [mips_isa_pkg::SHAMT_W-1:0] sh_amt;
    mips_isa_pkg::word_t              logic_res;
    mips_isa_pkg::word_t              shift_res;
    mips_isa_pkg::word_t              arith_res;
    mips_isa_pkg::word_t              alu_res;
    core_pipe_pkg::wb_t               wb_q;
    logic                             wb_valid_q;

    assign sh_amt = id_ex_i.operand_a[mips_isa_pkg::SHAMT_W-1:0];

    always_comb begin
        case (id_ex_i.alu_op)
            core_pipe_pkg::ALU_AND: logic_res = id_ex_i.operand_a & id_ex_i.operand_b;
            core_pipe_pkg::ALU_XOR: logic_res = id_ex_i.operand_a ^ id_ex_i.operand_b;
            core_pipe_pkg::ALU_NOR: logic_res = ~(id_ex_i.operand_a | id_ex_i.operand_b);
            default:                logic_res = id_ex_i.operand_a | id_ex_i.operand_b;
        endcase
    end

    // value to shift sits in operand_b
    always_comb begin
        case (id_ex_i.alu_op)
            core_pipe_pkg::ALU_SRL: shift_res = id_ex_i.operand_b >> sh_amt;
            core_pipe_pkg::ALU_SRA: shift_res = $signed(id_ex_i.operand_b) >>> sh_amt;
            default:                shift_res = id_ex_i.operand_b << sh_amt;
        endcase
    end

    // add and sub simply wrap
    always_comb begin
        case (id_ex_i.alu_op)
            core_pipe_pkg::ALU_SUB: begin
                arith_res = id_ex_i.operand_a - id_ex_i.operand_b;
            end
            core_pipe_pkg::ALU_SLT: begin
                arith_res = mips_isa_pkg::word_t'($signed(id_ex_i.operand_a)
                                                  < $signed(id_ex_i.operand_b));
            end
            core_pipe_pkg::ALU_SLTU: begin
                arith_res = mips_isa_pkg::word_t'(id_ex_i.operand_a < id_ex_i.operand_b);
            end
            default: begin
                arith_res = id_ex_i.operand_a + id_ex_i.operand_b;
            end
        endcase
    end

    always_comb begin
        case (core_pipe_pkg::alu_class(id_ex_i.alu_op))
            core_pipe_pkg::RES_LOGIC: alu_res = logic_res;
            core_pipe_pkg::RES_SHIFT: alu_res = shift_res;
            default:                  alu_res = arith_res;
        endcase
    end

    always_comb begin
        ex_fwd_o.valid = id_ex_i.valid;
        ex_fwd_o.dest  = id_ex_i.dest;
        ex_fwd_o.data  = alu_res;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= ex_fwd_o.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= ex_fwd_o;
    end

    always_comb begin
        wb_fwd_o       = wb_q;
        wb_fwd_o.valid = wb_valid_q;
    end

    // nothing may commit on the first edge out of reset
    quiet_after_reset_a: assert property (
        @(posedge clk)
        $rose(arst_n_i) |-> !wb_fwd_o.valid
    ) else $error("writeback valid right after reset release");

endmodule

// File: source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    inst_valid_i,
    input  mips_isa_pkg::inst_t     inst_i,
    output mips_isa_pkg::reg_addr_t rs_addr_o,
    output mips_isa_pkg::reg_addr_t rt_addr_o,
    input  mips_isa_pkg::word_t     rs_data_i,
    input  mips_isa_pkg::word_t     rt_data_i,
    input  core_pipe_pkg::wb_t      ex_fwd_i,
    input  core_pipe_pkg::wb_t      wb_fwd_i,
    output core_pipe_pkg::id_ex_t   id_ex_o
);

    logic [mips_isa_pkg::IMM_W-1:0] imm16;
    mips_isa_pkg::word_t            imm;
    mips_isa_pkg::reg_addr_t        dest;
    core_pipe_pkg::alu_op_e         alu_op;
    logic                           known;
    logic                           read_a;
    logic                           read_b;
    core_pipe_pkg::id_ex_t          id_ex_d;
    core_pipe_pkg::id_ex_t          pay_q;
    logic                           valid_q;

    // unread side takes the immediate; else execute, writeback, register file
    function automatic mips_isa_pkg::word_t pick_operand(
        input logic                    rd_en,
        input mips_isa_pkg::reg_addr_t addr,
        input mips_isa_pkg::word_t     rf_data,
        input mips_isa_pkg::word_t     imm_val,
        input core_pipe_pkg::wb_t      ex_fwd,
        input core_pipe_pkg::wb_t      wb_fwd
    );
        if (!rd_en) begin
            return imm_val;
        end else if (ex_fwd.valid && (ex_fwd.dest == addr)) begin
            return ex_fwd.data;
        end else if (wb_fwd.valid && (wb_fwd.dest == addr)) begin
            return wb_fwd.data;
        end
        return rf_data;
    endfunction

    assign imm16     = inst_i[mips_isa_pkg::IMM_W-1:0];
    assign rs_addr_o = inst_i.rs;
    assign rt_addr_o = inst_i.rt;

    always_comb begin
        alu_op = core_pipe_pkg::ALU_OR;
        known  = 1'b0;
        read_a = 1'b0;
        read_b = 1'b0;
        dest   = inst_i.rt;
        imm    = '0;
        case (inst_i.op)
            mips_isa_pkg::OP_SPECIAL: begin
                known  = 1'b1;
                read_a = 1'b1;
                read_b = 1'b1;
                dest   = inst_i.rd;
                case (inst_i.funct)
                    mips_isa_pkg::FN_OR:   alu_op = core_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_AND:  alu_op = core_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_XOR:  alu_op = core_pipe_pkg::ALU_XOR;
                    mips_isa_pkg::FN_NOR:  alu_op = core_pipe_pkg::ALU_NOR;
                    mips_isa_pkg::FN_SLLV: alu_op = core_pipe_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRLV: alu_op = core_pipe_pkg::ALU_SRL;
                    mips_isa_pkg::FN_SRAV: alu_op = core_pipe_pkg::ALU_SRA;
                    // no overflow trap, add behaves like addu
                    mips_isa_pkg::FN_ADD,
                    mips_isa_pkg::FN_ADDU: alu_op = core_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUB,
                    mips_isa_pkg::FN_SUBU: alu_op = core_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_SLT:  alu_op = core_pipe_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: alu_op = core_pipe_pkg::ALU_SLTU;
                    mips_isa_pkg::FN_SLL,
                    mips_isa_pkg::FN_SRL,
                    mips_isa_pkg::FN_SRA: begin
                        // shift amount from the instruction
                        read_a = 1'b0;
                        imm    = mips_isa_pkg::word_t'(inst_i.shamt);
                        if (inst_i.funct == mips_isa_pkg::FN_SLL) begin
                            alu_op = core_pipe_pkg::ALU_SLL;
                        end else if (inst_i.funct == mips_isa_pkg::FN_SRL) begin
                            alu_op = core_pipe_pkg::ALU_SRL;
                        end else begin
                            alu_op = core_pipe_pkg::ALU_SRA;
                        end
                    end
                    default: known = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ORI,
            mips_isa_pkg::OP_ANDI,
            mips_isa_pkg::OP_XORI: begin
                known  = 1'b1;
                read_a = 1'b1;
                imm    = mips_isa_pkg::word_t'(imm16);
                if (inst_i.op == mips_isa_pkg::OP_ORI) begin
                    alu_op = core_pipe_pkg::ALU_OR;
                end else if (inst_i.op == mips_isa_pkg::OP_ANDI) begin
                    alu_op = core_pipe_pkg::ALU_AND;
                end else begin
                    alu_op = core_pipe_pkg::ALU_XOR;
                end
            end
            mips_isa_pkg::OP_LUI: begin
                // both sides carry the immediate, OR passes it through
                known = 1'b1;
                imm   = {imm16, {mips_isa_pkg::IMM_W{1'b0}}};
            end
            mips_isa_pkg::OP_ADDI,
            mips_isa_pkg::OP_ADDIU,
            mips_isa_pkg::OP_SLTI,
            mips_isa_pkg::OP_SLTIU: begin
                known  = 1'b1;
                read_a = 1'b1;
                imm    = mips_isa_pkg::word_t'($signed(imm16));
                if (inst_i.op == mips_isa_pkg::OP_SLTI) begin
                    alu_op = core_pipe_pkg::ALU_SLT;
                end else if (inst_i.op == mips_isa_pkg::OP_SLTIU) begin
                    alu_op = core_pipe_pkg::ALU_SLTU;
                end else begin
                    alu_op = core_pipe_pkg::ALU_ADD;
                end
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        id_ex_d.valid     = inst_valid_i && known && (dest != '0);
        id_ex_d.alu_op    = alu_op;
        id_ex_d.operand_a = pick_operand(read_a, inst_i.rs, rs_data_i, imm,
                                         ex_fwd_i, wb_fwd_i);
        id_ex_d.operand_b = pick_operand(read_b, inst_i.rt, rt_data_i, imm,
                                         ex_fwd_i, wb_fwd_i);
        id_ex_d.dest      = dest;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= id_ex_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        pay_q <= id_ex_d;
    end

    always_comb begin
        id_ex_o       = pay_q;
        id_ex_o.valid = valid_q;
    end

    // a registered write to r0 would also corrupt the forwarding match
    issue_no_r0_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        id_ex_o.valid |-> (id_ex_o.dest != '0)
    ) else $error("decode issued a write to r0");

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  mips_isa_pkg::reg_addr_t rs_addr_i,
    input  mips_isa_pkg::reg_addr_t rt_addr_i,
    output mips_isa_pkg::word_t     rs_data_o,
    output mips_isa_pkg::word_t     rt_data_o,
    input  core_pipe_pkg::wb_t      wr_i
);

    // r0 is not stored
    mips_isa_pkg::word_t regs [1:mips_isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < mips_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && (wr_i.dest != '0)) begin
            regs[wr_i.dest] <= wr_i.data;
        end
    end

    // same-cycle writes are covered by the forwarding paths in decode
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    // decode drops writes to r0, so none should reach the port
    wr_no_r0_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wr_i.valid |-> (wr_i.dest != '0)
    ) else $error("register file write to r0");

endmodule

// File: source/core_pipe_pkg.sv
package core_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // which result group an operation draws from
    typedef enum logic [1:0] {
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH
    } res_class_e;

    function automatic res_class_e alu_class(input alu_op_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: begin
                return RES_LOGIC;
            end
            ALU_SLL, ALU_SRL, ALU_SRA: begin
                return RES_SHIFT;
            end
            default: begin
                return RES_ARITH;
            end
        endcase
    endfunction

    // decode to execute; for shifts operand_a carries the amount
    typedef struct packed {
        logic                    valid;
        alu_op_e                 alu_op;
        mips_isa_pkg::word_t     operand_a;
        mips_isa_pkg::word_t     operand_b;
        mips_isa_pkg::reg_addr_t dest;
    } id_ex_t;

    // register write, also used for both forwarding paths
    typedef struct packed {
        logic                    valid;
        mips_isa_pkg::reg_addr_t dest;
        mips_isa_pkg::word_t     data;
    } wb_t;

endpackage

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

    // architectural widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int OP_W       = 6;
    localparam int FN_W       = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OP_W-1:0]       opcode_t;
    typedef logic [FN_W-1:0]       funct_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    // R-type field layout; I-type immediate overlays rd, shamt and funct
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        funct_t    funct;
    } inst_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL function codes
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage
